// File: design/cdr_pkg.sv
`default_nettype none

package cdr_pkg;

    //////////////////////////////////////////////////
    // widths

    localparam int adc_width = 8;
    localparam int nti       = 4;   // interleaved lanes per clock
    localparam int pi_width  = 8;
    localparam int est_width = 32;  // estimator accumulators

    typedef logic signed [adc_width-1:0] adc_code_t;
    typedef logic signed [adc_width+2:0] pd_err_t;    // sum over nti-1 lane pairs
    typedef logic        [3:0]           gain_t;      // shift amount
    typedef logic        [pi_width-1:0]  pi_code_t;
    typedef logic        [7:0]           apb_addr_t;
    typedef logic        [31:0]          apb_data_t;
    typedef logic signed [est_width-1:0] est_t;
    typedef logic        [est_width-2:0] clamp_t;     // unsigned, fits a positive est_t

    //////////////////////////////////////////////////
    // register map

    typedef enum logic [7:0] {
        REG_CTRL       = 8'h00,
        REG_GAIN       = 8'h04,
        REG_CLAMP      = 8'h08,
        REG_PD_OFFSET  = 8'h0C,
        REG_EXT_PI     = 8'h10,
        REG_SNAP_CMD   = 8'h14,
        REG_SNAP_PHASE = 8'h18,
        REG_SNAP_FREQ  = 8'h1C,
        REG_SNAP_RAMP  = 8'h20,
        REG_STATUS     = 8'h24
    } reg_addr_e;

    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        CAPTURE
    } snap_state_e;

    //////////////////////////////////////////////////
    // bundles between control and datapath

    typedef struct packed {
        logic      en_freq;     // REG_CTRL[0]
        logic      en_ramp;     // REG_CTRL[1]
        logic      en_clamp;    // REG_CTRL[2]
        logic      en_ext_pi;   // REG_CTRL[3]
        gain_t     kp;
        gain_t     ki;
        gain_t     kr;
        clamp_t    clamp_amt;
        adc_code_t pd_offset;
        pi_code_t  ext_pi;
    } cdr_cfg_t;

    typedef struct packed {
        pi_code_t phase_code;
        est_t     freq_update;
        est_t     ramp_sel;     // ramp accumulator picked by the ramp level
    } loop_state_t;

endpackage

`default_nettype wire

// File: design/mm_pd.sv
`timescale 1ns/10ps
`default_nettype none

module mm_pd (
    input  wire cdr_pkg::adc_code_t [cdr_pkg::nti-1:0] codes_i,
    input  wire logic [cdr_pkg::nti-1:0]              bits_i,
    input  wire cdr_pkg::adc_code_t                   offset_i,
    output cdr_pkg::pd_err_t                          err_o
);
    import cdr_pkg::*;

    // wide enough for the raw sum plus offset, never wraps
    localparam int sum_width = adc_width + 5;

    typedef logic signed [sum_width-1:0] sum_t;

    localparam sum_t err_max = sum_t'(2 ** (adc_width + 2) - 1);
    localparam sum_t err_min = -err_max - sum_t'(1);

    sum_t sum_raw;

    // code times sign of the neighbour's sliced bit
    function automatic sum_t mm_term(adc_code_t code, logic bit_pos);
        sum_t code_ext;
        code_ext = sum_t'(code);
        return bit_pos ? code_ext : -code_ext;
    endfunction

    //////////////////////////////////////////////////
    // mueller-muller sum over neighbouring lanes

    always_comb begin
        sum_raw = sum_t'(offset_i);
        for (int k = 1; k < nti; k++) begin
            sum_raw = sum_raw + mm_term(codes_i[k], bits_i[k-1])
                              - mm_term(codes_i[k-1], bits_i[k]);
        end
    end

    // clip to the pd_err_t range
    always_comb begin
        if (sum_raw > err_max) begin
            err_o = pd_err_t'(err_max);
        end else if (sum_raw < err_min) begin
            err_o = pd_err_t'(err_min);
        end else begin
            err_o = pd_err_t'(sum_raw);
        end
    end

endmodule

`default_nettype wire

// File: design/ramp_est.sv
`timescale 1ns/10ps
`default_nettype none

module ramp_est #(
    parameter int phase_shift = 16
) (
    input  wire logic             clk,
    input  wire logic             ext_rstb,
    input  wire logic             ramp_clk_i,
    input  wire cdr_pkg::pd_err_t  err_i,
    input  wire cdr_pkg::cdr_cfg_t cfg_i,
    output cdr_pkg::est_t         ramp_term_o,
    output cdr_pkg::est_t         ramp_sel_o
);
    import cdr_pkg::*;

    // the ramp terms feed the phase accumulator through the frequency path,
    // so the estimator needs headroom above the phase code bits
    if (phase_shift + pi_width >= est_width) begin : g_width_chk
        $error("ramp_est: est_width too small for phase_shift");
    end

    logic ramp_meta;
    logic ramp_sync;
    est_t err_gain;
    est_t pls_q;
    est_t neg_q;

    assign err_gain = (-est_t'(err_i)) <<< cfg_i.kr;  // loop runs on the negated error

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            ramp_meta <= 1'b0;
            ramp_sync <= 1'b0;
            pls_q     <= '0;
            neg_q     <= '0;
        end else begin
            ramp_meta <= ramp_clk_i;    // 2-flop sync
            ramp_sync <= ramp_meta;
            if (!cfg_i.en_ramp) begin
                pls_q <= '0;
                neg_q <= '0;
            end else if (ramp_sync) begin
                pls_q <= pls_q + err_gain;
            end else begin
                neg_q <= neg_q + err_gain;
            end
        end
    end

    assign ramp_term_o = ramp_sync ? pls_q : -neg_q;
    assign ramp_sel_o  = ramp_sync ? pls_q : neg_q;

endmodule

`default_nettype wire

// File: design/loop_filter.sv
`timescale 1ns/10ps
`default_nettype none

module loop_filter #(
    parameter int phase_shift = 16,
    parameter int nout        = 2
) (
    input  wire logic                       clk,
    input  wire logic                       ext_rstb,
    input  wire cdr_pkg::pd_err_t            err_i,
    input  wire cdr_pkg::est_t               ramp_term_i,
    input  wire cdr_pkg::cdr_cfg_t           cfg_i,
    output cdr_pkg::pi_code_t [nout-1:0]    pi_ctl_o,
    output logic                            freq_cross_o,
    output cdr_pkg::pi_code_t               phase_code_o,
    output cdr_pkg::est_t                   freq_update_o
);
    import cdr_pkg::*;

    est_t     err_q;        // negated detector output
    est_t     freq_q;
    est_t     phase_q;
    est_t     prev_upd_q;
    est_t     freq_update;
    est_t     step;
    est_t     step_c;
    est_t     clamp_max;
    pi_code_t phase_code;

    //////////////////////////////////////////////////
    // integrators

    assign freq_update = (err_q <<< cfg_i.ki) + ramp_term_i;
    assign step        = (err_q <<< cfg_i.kp) + freq_q;
    assign clamp_max   = est_t'({1'b0, cfg_i.clamp_amt});

    // optional limit on the per-cycle phase step
    always_comb begin
        step_c = step;
        if (cfg_i.en_clamp) begin
            if (step > clamp_max) begin
                step_c = clamp_max;
            end else if (step < -clamp_max) begin
                step_c = -clamp_max;
            end
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            err_q        <= '0;
            freq_q       <= '0;
            phase_q      <= '0;
            prev_upd_q   <= '0;
            freq_cross_o <= 1'b0;
        end else begin
            err_q      <= -est_t'(err_i);
            prev_upd_q <= freq_update;
            if (cfg_i.en_freq) begin
                freq_q <= freq_q + freq_update;
            end
            if (cfg_i.en_ext_pi) begin
                phase_q <= est_t'(cfg_i.ext_pi) << phase_shift;  // preload from override
            end else begin
                phase_q <= phase_q + step_c;
            end
            freq_cross_o <= freq_update > prev_upd_q;   // rising level crossing
        end
    end

    //////////////////////////////////////////////////
    // output codes

    assign phase_code    = phase_q[phase_shift +: pi_width];
    assign phase_code_o  = phase_code;
    assign freq_update_o = freq_update;

    always_comb begin
        for (int k = 0; k < nout; k++) begin
            pi_ctl_o[k] = cfg_i.en_ext_pi ? cfg_i.ext_pi : phase_code;
        end
    end

    // accumulator never moves by more than the clamp
    a_step_clamped: assert property (@(posedge clk) disable iff (!ext_rstb)
        cfg_i.en_clamp && !cfg_i.en_ext_pi |=>
            (phase_q - $past(phase_q) <= $past(clamp_max)) &&
            ($past(phase_q) - phase_q <= $past(clamp_max)));

endmodule

`default_nettype wire

// File: design/cdr_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cdr_ctrl (
    input  wire logic                 clk,
    input  wire logic                 ext_rstb,
    input  wire logic                 psel_i,
    input  wire logic                 penable_i,
    input  wire logic                 pwrite_i,
    input  wire cdr_pkg::apb_addr_t    paddr_i,
    input  wire cdr_pkg::apb_data_t    pwdata_i,
    output cdr_pkg::apb_data_t        prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    input  wire cdr_pkg::loop_state_t  loop_state_i,
    input  wire logic                 freq_cross_i,
    output cdr_pkg::cdr_cfg_t         cfg_o
);
    import cdr_pkg::*;

    logic        access;
    logic        wr_en;
    logic        snap_cmd;
    logic        addr_hit;
    reg_addr_e   addr;
    cdr_cfg_t    cfg_q;
    snap_state_e state_q;
    logic        snap_valid_q;
    pi_code_t    snap_phase_q;
    est_t        snap_freq_q;
    est_t        snap_ramp_q;

    assign access    = psel_i & penable_i;
    assign wr_en     = access & pwrite_i;
    assign addr      = reg_addr_e'(paddr_i);
    assign snap_cmd  = wr_en && (addr == REG_SNAP_CMD);
    assign pready_o  = 1'b1;                // no wait states
    assign pslverr_o = access & ~addr_hit;
    assign cfg_o     = cfg_q;

    //////////////////////////////////////////////////
    // config writes

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            cfg_q <= '0;
        end else if (wr_en) begin
            case (addr)
                REG_CTRL: begin
                    cfg_q.en_freq   <= pwdata_i[0];
                    cfg_q.en_ramp   <= pwdata_i[1];
                    cfg_q.en_clamp  <= pwdata_i[2];
                    cfg_q.en_ext_pi <= pwdata_i[3];
                end
                REG_GAIN: begin
                    cfg_q.kp <= pwdata_i[3:0];
                    cfg_q.ki <= pwdata_i[7:4];
                    cfg_q.kr <= pwdata_i[11:8];
                end
                REG_CLAMP:     cfg_q.clamp_amt <= pwdata_i[est_width-2:0];
                REG_PD_OFFSET: cfg_q.pd_offset <= pwdata_i[adc_width-1:0];
                REG_EXT_PI:    cfg_q.ext_pi    <= pwdata_i[pi_width-1:0];
                default: ;  // snapshot and status are read only
            endcase
        end
    end

    //////////////////////////////////////////////////
    // read mux

    always_comb begin
        prdata_o = '0;
        addr_hit = 1'b1;
        case (addr)
            REG_CTRL: begin
                prdata_o[3:0] = {cfg_q.en_ext_pi, cfg_q.en_clamp,
                                 cfg_q.en_ramp, cfg_q.en_freq};
            end
            REG_GAIN:       prdata_o[11:0] = {cfg_q.kr, cfg_q.ki, cfg_q.kp};
            REG_CLAMP:      prdata_o[est_width-2:0] = cfg_q.clamp_amt;
            REG_PD_OFFSET:  prdata_o[adc_width-1:0] = cfg_q.pd_offset;
            REG_EXT_PI:     prdata_o[pi_width-1:0] = cfg_q.ext_pi;
            REG_SNAP_CMD:   prdata_o = '0;
            REG_SNAP_PHASE: prdata_o[pi_width-1:0] = snap_phase_q;
            REG_SNAP_FREQ:  prdata_o = snap_freq_q;
            REG_SNAP_RAMP:  prdata_o = snap_ramp_q;
            REG_STATUS:     prdata_o[1:0] = {freq_cross_i, snap_valid_q};
            default:        addr_hit = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // snapshot fsm, cmd write -> armed -> capture

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state_q      <= IDLE;
            snap_valid_q <= 1'b0;
        end else if (snap_cmd) begin
            state_q      <= ARMED;  // restarts from any state
            snap_valid_q <= 1'b0;
        end else begin
            case (state_q)
                ARMED:   state_q <= CAPTURE;
                CAPTURE: begin
                    state_q      <= IDLE;
                    snap_valid_q <= 1'b1;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // frozen copy of the loop
    always_ff @(posedge clk) begin
        if (state_q == CAPTURE) begin
            snap_phase_q <= loop_state_i.phase_code;
            snap_freq_q  <= loop_state_i.freq_update;
            snap_ramp_q  <= loop_state_i.ramp_sel;
        end
    end

    // error only in an access phase that followed a setup phase
    a_slverr_access: assert property (@(posedge clk) disable iff (!ext_rstb)
        pslverr_o |-> psel_i && penable_i && $past(psel_i));

    a_valid_from_capture: assert property (@(posedge clk) disable iff (!ext_rstb)
        $rose(snap_valid_q) |-> $past(state_q) == CAPTURE);

endmodule

`default_nettype wire

// File: design/cdr_top.sv
`timescale 1ns/10ps
`default_nettype none

module cdr_top #(
    parameter int phase_shift = 16,
    parameter int nout        = 2
) (
    input  wire logic                                   clk,
    input  wire logic                                   ext_rstb,
    input  wire cdr_pkg::adc_code_t [cdr_pkg::nti-1:0]   codes_i,
    input  wire logic [cdr_pkg::nti-1:0]                bits_i,
    input  wire logic                                   ramp_clk_i,
    input  wire logic                                   psel_i,
    input  wire logic                                   penable_i,
    input  wire logic                                   pwrite_i,
    input  wire cdr_pkg::apb_addr_t                      paddr_i,
    input  wire cdr_pkg::apb_data_t                      pwdata_i,
    output cdr_pkg::apb_data_t                          prdata_o,
    output logic                                        pready_o,
    output logic                                        pslverr_o,
    output cdr_pkg::pi_code_t [nout-1:0]                pi_ctl_o,
    output logic                                        freq_cross_o
);
    import cdr_pkg::*;

    cdr_cfg_t    cfg;
    pd_err_t     pd_err;
    est_t        ramp_term;
    est_t        ramp_sel;
    est_t        freq_update;
    pi_code_t    phase_code;
    loop_state_t loop_state;

    assign loop_state = '{phase_code: phase_code, freq_update: freq_update, ramp_sel: ramp_sel};

    cdr_ctrl u_ctrl (
        .clk(clk), .ext_rstb(ext_rstb),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o),
        .loop_state_i(loop_state), .freq_cross_i(freq_cross_o), .cfg_o(cfg)
    );

    mm_pd u_pd (.codes_i(codes_i), .bits_i(bits_i), .offset_i(cfg.pd_offset), .err_o(pd_err));

    ramp_est #(.phase_shift(phase_shift)) u_ramp (
        .clk(clk), .ext_rstb(ext_rstb), .ramp_clk_i(ramp_clk_i), .err_i(pd_err),
        .cfg_i(cfg), .ramp_term_o(ramp_term), .ramp_sel_o(ramp_sel)
    );

    loop_filter #(.phase_shift(phase_shift), .nout(nout)) u_loop (
        .clk(clk), .ext_rstb(ext_rstb), .err_i(pd_err), .ramp_term_i(ramp_term),
        .cfg_i(cfg), .pi_ctl_o(pi_ctl_o), .freq_cross_o(freq_cross_o),
        .phase_code_o(phase_code), .freq_update_o(freq_update)
    );

endmodule

`default_nettype wire

// File: testbench/cdr_tb_tasks.svh
`ifndef CDR_TB_TASKS_SVH
`define CDR_TB_TASKS_SVH

task automatic stop_with_failure(string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1);
endtask

task automatic check_data(apb_data_t got, apb_data_t exp, string what);
    if (got !== exp) stop_with_failure($sformatf("error %0t: %s got %h expected %h",
                                                 $time, what, got, exp));
endtask

task automatic check_pi(pi_code_t got, pi_code_t exp, string what);
    if (got !== exp) stop_with_failure($sformatf("error %0t: %s got %0d expected %0d",
                                                 $time, what, got, exp));
endtask

task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) stop_with_failure($sformatf("error %0t: %s got %b expected %b",
                                                 $time, what, got, exp));
endtask

//////////////////////////////////////////////////
// bus and reset

task automatic reset_dut();
    {psel, penable, pwrite, paddr, pwdata} = '0;
    codes     = '0;
    bits      = '0;
    ramp_clk  = 1'b0;
    ext_rstb  = 1'b0;
    {m_err, m_freq, m_phase, m_prev_upd, m_pls, m_neg, m_last_upd, m_clamp} = '0;
    {m_meta, m_sync, m_cross, m_last_code, m_kp, m_ki, m_kr} = '0;
    {m_en_freq, m_en_ramp, m_en_clamp, m_offset} = '0;
    repeat (4) @(negedge clk);
    ext_rstb = 1'b1;
endtask

task automatic apb_write(apb_addr_t addr, apb_data_t data);
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;                 // takes effect at the next rising edge
    @(negedge clk);
    {psel, penable, pwrite} = '0;
endtask

task automatic apb_read(apb_addr_t addr, output apb_data_t data, output logic err);
    psel  = 1'b1;
    paddr = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    err  = pslverr;
    check_flag(pready, 1'b1, "pready");
    @(negedge clk);
    {psel, penable} = '0;
endtask

//////////////////////////////////////////////////
// reference model

function automatic lanes_t rand_lanes();
    lanes_t c;
    for (int k = 0; k < nti; k++) c[k] = adc_code_t'($urandom);
    return c;
endfunction

// mueller-muller sum, saturated
function automatic int mm_ref(lanes_t c, logic [nti-1:0] b, adc_code_t ofs);
    int sum;
    int lim;
    lim = 2 ** (adc_width + 2);
    sum = ofs;
    for (int k = 1; k < nti; k++) begin
        sum += (b[k-1] ? int'(c[k]) : -int'(c[k])) - (b[k] ? int'(c[k-1]) : -int'(c[k-1]));
    end
    if (sum > lim - 1) sum = lim - 1;
    else if (sum < -lim) sum = -lim;
    return sum;
endfunction

function automatic pi_code_t m_code();
    return m_phase[phase_shift +: pi_width];
endfunction

// one rising edge of the loop, from the values just before it
task automatic model_step(lanes_t c, logic [nti-1:0] b, logic r);
    est_t e_now;
    est_t ramp_term;
    est_t upd;
    est_t step;
    e_now     = -est_t'(mm_ref(c, b, m_offset));
    ramp_term = m_sync ? m_pls : -m_neg;
    upd       = (m_err <<< m_ki) + ramp_term;
    step      = (m_err <<< m_kp) + m_freq;
    if (m_en_clamp && step > m_clamp) step = m_clamp;
    else if (m_en_clamp && step < -m_clamp) step = -m_clamp;
    m_last_upd  = upd;
    m_last_code = m_code();
    m_cross     = upd > m_prev_upd;
    m_prev_upd  = upd;
    if (m_en_freq) m_freq += upd;
    m_phase += step;
    if (!m_en_ramp) {m_pls, m_neg} = '0;
    else if (m_sync) m_pls += e_now <<< m_kr;
    else m_neg += e_now <<< m_kr;
    m_sync = m_meta;                // two-flop sync
    m_meta = r;
    m_err  = e_now;
endtask

task automatic run_cycle(lanes_t c, logic [nti-1:0] b, logic r);
    codes    = c;
    bits     = b;
    ramp_clk = r;
    model_step(c, b, r);
    @(negedge clk);
endtask

`endif

// File: testbench/cdr_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cdr_tb;
    import cdr_pkg::*;

    localparam int phase_shift = 16;
    localparam int nout        = 2;
    localparam int max_cycles  = 2000;  // all tests together stay well under 400

    typedef adc_code_t [nti-1:0] lanes_t;

    logic                  clk;
    logic                  ext_rstb;
    lanes_t                codes;
    logic [nti-1:0]        bits;
    logic                  ramp_clk;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    apb_addr_t             paddr;
    apb_data_t             pwdata;
    apb_data_t             prdata;
    logic                  pready;
    logic                  pslverr;
    pi_code_t [nout-1:0]   pi_ctl;
    logic                  freq_cross;
    int                    cycle_cnt;

    // reference model state
    est_t      m_err;
    est_t      m_freq;
    est_t      m_phase;
    est_t      m_prev_upd;
    est_t      m_pls;
    est_t      m_neg;
    est_t      m_last_upd;
    est_t      m_clamp;
    logic      m_meta;
    logic      m_sync;
    logic      m_cross;
    pi_code_t  m_last_code;
    gain_t     m_kp;
    gain_t     m_ki;
    gain_t     m_kr;
    logic      m_en_freq;
    logic      m_en_ramp;
    logic      m_en_clamp;
    adc_code_t m_offset;

    cdr_top #(.phase_shift(phase_shift), .nout(nout)) DUT (
        .clk(clk), .ext_rstb(ext_rstb), .codes_i(codes), .bits_i(bits),
        .ramp_clk_i(ramp_clk), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
        .pslverr_o(pslverr), .pi_ctl_o(pi_ctl), .freq_cross_o(freq_cross)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            stop_with_failure($sformatf("timeout: run went past %0d cycles", max_cycles));
        end
    end

    `include "cdr_tb_tasks.svh"

    //////////////////////////////////////////////////
    // directed tests

    task automatic test_registers();
        apb_addr_t addrs[5] = '{REG_CTRL, REG_GAIN, REG_CLAMP, REG_PD_OFFSET, REG_EXT_PI};
        apb_data_t masks[5] = '{32'hf, 32'hfff, 32'h7fff_ffff, 32'hff, 32'hff};
        apb_data_t val;
        apb_data_t rd;
        logic      err;
        for (int i = 0; i < 5; i++) begin
            val = $urandom & masks[i];
            apb_write(addrs[i], val);
            apb_read(addrs[i], rd, err);
            check_data(rd, val, "register readback");
            check_flag(err, 1'b0, "pslverr on mapped address");
        end
        apb_read(8'h28, rd, err);
        check_flag(err, 1'b1, "pslverr on unmapped address");
    endtask

    task automatic test_override();
        pi_code_t ext;
        ext = pi_code_t'($urandom);
        reset_dut();
        apb_write(REG_EXT_PI, apb_data_t'(ext));
        apb_write(REG_CTRL, 32'h8);
        for (int k = 0; k < nout; k++) check_pi(pi_ctl[k], ext, "override copy");
        apb_write(REG_CTRL, 32'h0);         // release, error stays zero
        repeat (5) begin
            @(negedge clk);
            for (int k = 0; k < nout; k++) check_pi(pi_ctl[k], ext, "held after release");
        end
    endtask

    task automatic test_proportional();
        reset_dut();
        m_kp     = 4'd10;
        m_offset = adc_code_t'($urandom);
        apb_write(REG_GAIN, 32'h00a);
        apb_write(REG_PD_OFFSET, apb_data_t'(m_offset));   // offset joins from the first group
        for (int i = 0; i < 30; i++) begin
            run_cycle(rand_lanes(), nti'($urandom), 1'b0);
            for (int k = 0; k < nout; k++) check_pi(pi_ctl[k], m_code(), "proportional path");
        end
    endtask

    task automatic test_clamp();
        reset_dut();
        m_kp       = 4'd10;
        m_clamp    = est_t'(3 << phase_shift);  // three codes per cycle
        m_en_clamp = 1'b1;
        apb_write(REG_GAIN, 32'h00a);
        apb_write(REG_CLAMP, apb_data_t'(m_clamp));
        apb_write(REG_CTRL, 32'h4);
        for (int i = 0; i < 20; i++) begin
            run_cycle('{default: adc_code_t'(100)}, 4'b0101, 1'b0);
            check_pi(pi_ctl[0], m_code(), "clamped phase");
            check_pi(pi_ctl[0], pi_code_t'(-3 * i), "step equals clamp");  // down 3 per cycle
        end
    endtask

    task automatic test_snapshot();
        pi_code_t  exp_code;
        est_t      exp_upd;
        apb_data_t rd;
        logic      err;
        reset_dut();
        m_kp      = 4'd4;
        m_ki      = 4'd14;
        m_en_freq = 1'b1;
        apb_write(REG_GAIN, 32'h0e4);
        apb_write(REG_CTRL, 32'h1);
        for (int i = 0; i < 6; i++) begin
            case (i)
                0: begin
                    psel    = 1'b1;
                    pwrite  = 1'b1;
                    paddr   = REG_SNAP_CMD;
                end
                1: penable = 1'b1;          // write edge
                2: begin
                    psel    = 1'b0;
                    penable = 1'b0;
                    pwrite  = 1'b0;
                end
                default: ;
            endcase
            run_cycle('{default: adc_code_t'(20)}, 4'b0101, 1'b0);
            if (i == 3) begin               // capture edge, two after the write
                exp_code = m_last_code;
                exp_upd  = m_last_upd;
            end
        end
        apb_read(REG_SNAP_PHASE, rd, err);
        check_data(rd, apb_data_t'(exp_code), "snapshot phase");
        apb_read(REG_SNAP_FREQ, rd, err);
        check_data(rd, apb_data_t'(exp_upd), "snapshot freq_update");
        apb_read(REG_STATUS, rd, err);
        check_flag(rd[0], 1'b1, "snapshot valid");
    endtask

    task automatic test_crossing();
        reset_dut();
        m_ki      = 4'd1;
        m_kr      = 4'd2;
        m_en_freq = 1'b1;
        m_en_ramp = 1'b1;
        apb_write(REG_GAIN, 32'h210);
        apb_write(REG_CTRL, 32'h3);
        psel  = 1'b1;                       // status stays in access phase
        paddr = REG_STATUS;
        @(negedge clk);
        penable = 1'b1;
        for (int i = 0; i < 60; i++) begin
            run_cycle(rand_lanes(), nti'($urandom), 1'((i / 4) % 2));
            check_flag(prdata[1], m_cross, "freq_cross in status");
            check_flag(freq_cross, m_cross, "freq_cross pin");
            check_pi(pi_ctl[0], m_code(), "phase with ramp");
        end
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h0ea2_4138));
        clk       = 1'b0;
        cycle_cnt = 0;
        reset_dut();
        test_registers();
        test_override();
        test_proportional();
        test_clamp();
        test_snapshot();
        test_crossing();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+testbench
design/cdr_pkg.sv
design/mm_pd.sv
design/ramp_est.sv
design/loop_filter.sv
design/cdr_ctrl.sv
design/cdr_top.sv
testbench/cdr_tb.sv
